// ==== Bender.yml ====
package:
  name: udp_tx

sources:
  - hw/eth_frame_pkg.sv
  - hw/udp_header_pkg.sv
  - hw/udp_header_gen.sv
  - hw/payload_fifo.sv
  - hw/eth_fcs_crc.sv
  - hw/udp_frame_tx.sv
  - hw/udp_tx_top.sv
  - target: simulation
    files:
      - verification/udp_tx_checker.sv
      - verification/udp_tx_assertions.sv
      - verification/udp_tx_tb.sv

// ==== hw/eth_fcs_crc.sv ====
module eth_fcs_crc (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        clear_i,
    input  logic        en_i,
    input  logic [7:0]  data_i,
    output logic [31:0] fcs_o
);
    import eth_frame_pkg::*;

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // bitwise lsb-first update, one byte per clock
    always_comb begin
        crc_next = crc_q;
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0] ^ data_i[i]) begin
                crc_next = (crc_next >> 1) ^ CRC32_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || clear_i) begin
            crc_q <= '1;
        end else if (en_i) begin
            crc_q <= crc_next;
        end
    end

    // low byte goes out first
    assign fcs_o = ~crc_q;

endmodule

// ==== hw/eth_frame_pkg.sv ====
package eth_frame_pkg;

    // on-wire framing, counted in GMII bytes
    localparam int PREAMBLE_BYTES = 7;
    localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0] SFD_BYTE = 8'hd5;
    localparam int FCS_BYTES = 4;
    localparam int IFG_BYTES = 12;
    localparam int HEADER_BYTES = 42;

    // no padding, so the sender keeps frames at or above the minimum
    localparam int MIN_PAYLOAD = 18;
    localparam int MAX_PAYLOAD = 1472;

    localparam int FIFO_DEPTH = 2048;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = FIFO_PTR_W + 1;
    localparam int LEN_W = 11;

    // reflected IEEE 802.3 polynomial
    localparam logic [31:0] CRC32_POLY = 32'hedb8_8320;

    typedef struct packed {
        logic       en;
        logic [7:0] d;
    } gmii_t;

endpackage

// ==== hw/payload_fifo.sv ====
module payload_fifo (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic                                 push_i,
    input  logic [7:0]                           wr_data_i,
    input  logic                                 pop_i,
    output logic [7:0]                           rd_data_o,
    output logic [eth_frame_pkg::FIFO_CNT_W-1:0] count_o
);
    import eth_frame_pkg::*;

    logic [7:0]            mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr_q;
    logic [FIFO_PTR_W-1:0] rd_ptr_q;
    logic [FIFO_CNT_W-1:0] count_q;

    // storage and read port
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
        if (pop_i) begin
            rd_data_o <= mem[rd_ptr_q];
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign count_o = count_q;

endmodule

// ==== hw/udp_frame_tx.sv ====
module udp_frame_tx (
    input  logic                                 clk_i,
    input  logic                                 rst_i,
    input  logic [7:0]                           s_data_i,
    input  logic [eth_frame_pkg::LEN_W-1:0]      s_len_i,
    input  logic                                 s_valid_i,
    input  logic                                 s_last_i,
    output logic                                 s_ready_o,
    output logic                                 fifo_push_o,
    output logic [7:0]                           fifo_data_o,
    output logic                                 fifo_pop_o,
    input  logic [7:0]                           fifo_data_i,
    input  logic [eth_frame_pkg::FIFO_CNT_W-1:0] fifo_count_i,
    output logic [eth_frame_pkg::LEN_W-1:0]      payload_len_o,
    input  udp_header_pkg::frame_hdr_t           hdr_i,
    output logic                                 crc_clear_o,
    output logic                                 crc_en_o,
    output logic [7:0]                           crc_data_o,
    input  logic [31:0]                          fcs_i,
    output eth_frame_pkg::gmii_t                 gmii_o
);
    import eth_frame_pkg::*;
    import udp_header_pkg::*;

    typedef enum logic [2:0] {
        ACCEPT,
        PREAMBLE,
        SFD,
        HEADER,
        PAYLOAD,
        FCS,
        GAP
    } state_t;

    localparam int HDR_W = $bits(frame_hdr_t);

    state_t             state_q;
    state_t             state_d;
    logic [LEN_W-1:0]   cnt_q;
    logic [LEN_W-1:0]   len_q;
    logic               first_q;
    logic               handshake;
    logic [HDR_W-1:0]   hdr_sr;
    logic [23:0]        fcs_sr;
    logic               tx_en;
    logic [7:0]         tx_byte;
    gmii_t              gmii_q;

    assign s_ready_o     = (state_q == ACCEPT);
    assign handshake     = s_valid_i && s_ready_o;
    assign fifo_push_o   = handshake;
    assign fifo_data_o   = s_data_i;
    assign payload_len_o = len_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ACCEPT: begin
                if (handshake && s_last_i) begin
                    state_d = PREAMBLE;
                end
            end
            PREAMBLE: begin
                if (cnt_q == LEN_W'(PREAMBLE_BYTES - 1)) begin
                    state_d = SFD;
                end
            end
            SFD: state_d = HEADER;
            HEADER: begin
                if (cnt_q == LEN_W'(HEADER_BYTES - 1)) begin
                    state_d = PAYLOAD;
                end
            end
            PAYLOAD: begin
                if (cnt_q == len_q - 1'b1) begin
                    state_d = FCS;
                end
            end
            FCS: begin
                if (cnt_q == LEN_W'(FCS_BYTES - 1)) begin
                    state_d = GAP;
                end
            end
            // one extra cycle covers the output register
            GAP: begin
                if (cnt_q == LEN_W'(IFG_BYTES)) begin
                    state_d = ACCEPT;
                end
            end
            default: state_d = ACCEPT;
        endcase
    end

    // byte lane and fifo prefetch, one cycle ahead of gmii
    always_comb begin
        tx_en      = 1'b1;
        tx_byte    = 8'h00;
        crc_en_o   = 1'b0;
        fifo_pop_o = 1'b0;
        case (state_q)
            PREAMBLE: tx_byte = PREAMBLE_BYTE;
            SFD:      tx_byte = SFD_BYTE;
            HEADER: begin
                tx_byte    = hdr_sr[HDR_W-1 -: 8];
                crc_en_o   = 1'b1;
                fifo_pop_o = (cnt_q == LEN_W'(HEADER_BYTES - 1));
            end
            PAYLOAD: begin
                tx_byte    = fifo_data_i;
                crc_en_o   = 1'b1;
                fifo_pop_o = (fifo_count_i != '0);
            end
            FCS: begin
                tx_byte = (cnt_q == '0) ? fcs_i[7:0] : fcs_sr[7:0];
            end
            default: tx_en = 1'b0;
        endcase
    end

    assign crc_clear_o = (state_q == PREAMBLE);
    assign crc_data_o  = tx_byte;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ACCEPT;
            cnt_q   <= '0;
            first_q <= 1'b1;
            gmii_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_d != state_q) begin
                cnt_q <= '0;
            end else if (state_q != ACCEPT) begin
                cnt_q <= cnt_q + 1'b1;
            end
            if (handshake) begin
                first_q <= s_last_i;
            end
            gmii_q.en <= tx_en;
            gmii_q.d  <= tx_byte;
        end
    end

    always_ff @(posedge clk_i) begin
        if (handshake && first_q) begin
            len_q <= s_len_i;
        end
        if (state_q == ACCEPT && state_d == PREAMBLE) begin
            hdr_sr <= hdr_i;
        end else if (state_q == HEADER) begin
            hdr_sr <= {hdr_sr[HDR_W-9:0], 8'h00};
        end
        // crc is idle during FCS, first byte goes out directly
        if (state_q == FCS) begin
            if (cnt_q == '0) begin
                fcs_sr <= fcs_i[31:8];
            end else begin
                fcs_sr <= {8'h00, fcs_sr[23:8]};
            end
        end
    end

    assign gmii_o = gmii_q;

endmodule

// ==== hw/udp_header_gen.sv ====
module udp_header_gen (
    input  udp_header_pkg::udp_endpoint_t local_i,
    input  udp_header_pkg::udp_endpoint_t remote_i,
    input  logic [eth_frame_pkg::LEN_W-1:0] payload_len_i,
    output udp_header_pkg::frame_hdr_t    hdr_o
);
    import udp_header_pkg::*;

    ipv4_hdr_u   ip_hdr;
    logic [15:0] udp_len;
    logic [15:0] ip_len;
    logic [19:0] word_sum;
    logic [16:0] fold_sum;
    logic [15:0] ip_csum;

    assign udp_len = 16'(payload_len_i) + UDP_HDR_BYTES;
    assign ip_len  = udp_len + IPV4_HDR_BYTES;

    // checksum field left at zero for the sum
    always_comb begin
        ip_hdr.f.ver_ihl    = IP_VER_IHL;
        ip_hdr.f.tos        = 8'h00;
        ip_hdr.f.total_len  = ip_len;
        ip_hdr.f.id         = 16'h0000;
        ip_hdr.f.flags_frag = IP_FLAGS_DF;
        ip_hdr.f.ttl        = IP_TTL;
        ip_hdr.f.protocol   = IP_PROTO_UDP;
        ip_hdr.f.checksum   = 16'h0000;
        ip_hdr.f.src_ip     = local_i.ip;
        ip_hdr.f.dst_ip     = remote_i.ip;
    end

    always_comb begin
        word_sum = '0;
        for (int i = 0; i < 10; i++) begin
            word_sum = word_sum + 20'(ip_hdr.w[i]);
        end
    end

    // two folds are enough for ten words
    assign fold_sum = {1'b0, word_sum[15:0]} + 17'(word_sum[19:16]);
    assign ip_csum  = ~(fold_sum[15:0] + 16'(fold_sum[16]));

    always_comb begin
        hdr_o.eth.dst_mac    = remote_i.mac;
        hdr_o.eth.src_mac    = local_i.mac;
        hdr_o.eth.ethertype  = ETHERTYPE_IPV4;
        hdr_o.ip             = ip_hdr;
        hdr_o.ip.f.checksum  = ip_csum;
        hdr_o.udp.src_port   = local_i.port;
        hdr_o.udp.dst_port   = remote_i.port;
        hdr_o.udp.length     = udp_len;
        // zero means no udp checksum
        hdr_o.udp.checksum   = 16'h0000;
    end

endmodule

// ==== hw/udp_header_pkg.sv ====
package udp_header_pkg;

    localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
    localparam logic [7:0] IP_VER_IHL = 8'h45;
    localparam logic [15:0] IP_FLAGS_DF = 16'h4000;
    localparam logic [7:0] IP_TTL = 8'd64;
    localparam logic [7:0] IP_PROTO_UDP = 8'd17;
    localparam logic [15:0] IPV4_HDR_BYTES = 16'd20;
    localparam logic [15:0] UDP_HDR_BYTES = 16'd8;

    typedef struct packed {
        logic [47:0] mac;
        logic [31:0] ip;
        logic [15:0] port;
    } udp_endpoint_t;

    typedef struct packed {
        logic [47:0] dst_mac;
        logic [47:0] src_mac;
        logic [15:0] ethertype;
    } eth_hdr_t;

    typedef struct packed {
        logic [7:0]  ver_ihl;
        logic [7:0]  tos;
        logic [15:0] total_len;
        logic [15:0] id;
        logic [15:0] flags_frag;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [15:0] checksum;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
    } ipv4_fields_t;

    // same bits, seen as fields or as checksum words
    typedef union packed {
        ipv4_fields_t     f;
        logic [9:0][15:0] w;
    } ipv4_hdr_u;

    typedef struct packed {
        logic [15:0] src_port;
        logic [15:0] dst_port;
        logic [15:0] length;
        logic [15:0] checksum;
    } udp_hdr_t;

    // msb is the first header byte on the wire
    typedef struct packed {
        eth_hdr_t  eth;
        ipv4_hdr_u ip;
        udp_hdr_t  udp;
    } frame_hdr_t;

endpackage

// ==== hw/udp_tx_top.sv ====
module udp_tx_top (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  udp_header_pkg::udp_endpoint_t   local_i,
    input  udp_header_pkg::udp_endpoint_t   remote_i,
    input  logic [7:0]                      s_data_i,
    input  logic [eth_frame_pkg::LEN_W-1:0] s_len_i,
    input  logic                            s_valid_i,
    input  logic                            s_last_i,
    output logic                            s_ready_o,
    output logic                            tx_en_o,
    output logic [7:0]                      tx_d_o
);
    import eth_frame_pkg::*;
    import udp_header_pkg::*;

    logic                  fifo_push;
    logic [7:0]            fifo_wr_data;
    logic                  fifo_pop;
    logic [7:0]            fifo_rd_data;
    logic [FIFO_CNT_W-1:0] fifo_count;
    logic [LEN_W-1:0]      payload_len;
    frame_hdr_t            hdr;
    logic                  crc_clear;
    logic                  crc_en;
    logic [7:0]            crc_data;
    logic [31:0]           fcs;
    gmii_t                 gmii;

    udp_frame_tx u_frame_tx (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .s_data_i     (s_data_i),
        .s_len_i      (s_len_i),
        .s_valid_i    (s_valid_i),
        .s_last_i     (s_last_i),
        .s_ready_o    (s_ready_o),
        .fifo_push_o  (fifo_push),
        .fifo_data_o  (fifo_wr_data),
        .fifo_pop_o   (fifo_pop),
        .fifo_data_i  (fifo_rd_data),
        .fifo_count_i (fifo_count),
        .payload_len_o(payload_len),
        .hdr_i        (hdr),
        .crc_clear_o  (crc_clear),
        .crc_en_o     (crc_en),
        .crc_data_o   (crc_data),
        .fcs_i        (fcs),
        .gmii_o       (gmii)
    );

    payload_fifo u_fifo (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .push_i   (fifo_push),
        .wr_data_i(fifo_wr_data),
        .pop_i    (fifo_pop),
        .rd_data_o(fifo_rd_data),
        .count_o  (fifo_count)
    );

    udp_header_gen u_header_gen (
        .local_i      (local_i),
        .remote_i     (remote_i),
        .payload_len_i(payload_len),
        .hdr_o        (hdr)
    );

    eth_fcs_crc u_fcs_crc (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .clear_i(crc_clear),
        .en_i   (crc_en),
        .data_i (crc_data),
        .fcs_o  (fcs)
    );

    assign tx_en_o = gmii.en;
    assign tx_d_o  = gmii.d;

endmodule

// ==== tb.f ====
hw/eth_frame_pkg.sv
hw/udp_header_pkg.sv
hw/udp_header_gen.sv
hw/payload_fifo.sv
hw/eth_fcs_crc.sv
hw/udp_frame_tx.sv
hw/udp_tx_top.sv
verification/udp_tx_checker.sv
verification/udp_tx_assertions.sv
verification/udp_tx_tb.sv

// ==== verification/udp_tx_assertions.sv ====
module udp_tx_assertions (
    input logic clk_i,
    input logic rst_i,
    input logic s_valid_i,
    input logic s_last_i,
    input logic s_ready_i,
    input logic tx_en_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    reset_idle: assert property (@(posedge clk_i) $fell(rst_i) |-> !tx_en_i)
        else begin
            fail_count++;
            $error("tx_en_o high in the first cycle after reset");
        end

    // at least the inter-frame gap after every frame
    gap_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(tx_en_i) |-> !tx_en_i [*12])
        else begin
            fail_count++;
            $error("tx_en_o rose again within 12 cycles of its fall");
        end

    busy_no_intake: assert property (@(posedge clk_i) disable iff (rst_i)
        tx_en_i |-> !s_ready_i)
        else begin
            fail_count++;
            $error("s_ready_o high while a frame is on gmii");
        end

    ready_drop: assert property (@(posedge clk_i) disable iff (rst_i)
        (s_valid_i && s_ready_i && s_last_i) |=> !s_ready_i)
        else begin
            fail_count++;
            $error("s_ready_o still high after the last byte");
        end

endmodule

bind udp_tx_top udp_tx_assertions u_assertions (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .s_valid_i(s_valid_i),
    .s_last_i (s_last_i),
    .s_ready_i(s_ready_o),
    .tx_en_i  (tx_en_o)
);

// ==== verification/udp_tx_checker.sv ====
module udp_tx_checker (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  udp_header_pkg::udp_endpoint_t   local_i,
    input  udp_header_pkg::udp_endpoint_t   remote_i,
    input  logic [7:0]                      s_data_i,
    input  logic [eth_frame_pkg::LEN_W-1:0] s_len_i,
    input  logic                            s_valid_i,
    input  logic                            s_last_i,
    input  logic                            s_ready_i,
    input  logic                            tx_en_i,
    input  logic [7:0]                      tx_d_i,
    output int                              errors_o,
    output int                              frames_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import udp_header_pkg::*;

    localparam int GAP_CYCLES = 12;
    localparam int START_DELAY = 2;

    logic [7:0]  pkt_q[$];
    logic [7:0]  exp_q[$];
    int          exp_len_q[$];
    longint      accept_q[$];
    logic [10:0] pkt_len;
    logic        first_byte;
    logic        in_frame;
    logic        hold_low;
    logic [7:0]  exp_byte;
    longint      cycle;
    longint      start;
    int          run;
    int          idle;
    int          exp_len;
    int          errors;
    int          frames;

    function automatic logic [15:0] ip_checksum(input logic [159:0] hdr);
        logic [31:0] sum;
        sum = '0;
        for (int i = 0; i < 10; i++) begin
            sum = sum + {16'h0000, hdr[i*16 +: 16]};
        end
        while (sum[31:16] != 16'h0000) begin
            sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
        end
        return ~sum[15:0];
    endfunction

    // eth, ipv4 and udp headers, first wire byte in the top bits
    function automatic logic [335:0] build_header(input udp_endpoint_t src,
                                                  input udp_endpoint_t dst,
                                                  input int len);
        logic [159:0] ip;
        logic [15:0]  udp_len;
        udp_len = 16'(len + 8);
        ip = {8'h45, 8'h00, 16'(len + 28), 16'h0000, 16'h4000, 8'd64, 8'd17,
              16'h0000, src.ip, dst.ip};
        ip[79:64] = ip_checksum(ip);
        return {dst.mac, src.mac, 16'h0800, ip, src.port, dst.port, udp_len, 16'h0000};
    endfunction

    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] b);
        logic [31:0] c;
        c = crc ^ {24'h000000, b};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
        end
        return c;
    endfunction

    task automatic queue_frame(input udp_endpoint_t src, input udp_endpoint_t dst);
        logic [335:0] hdr;
        logic [31:0]  crc;
        logic [7:0]   b;
        if (pkt_q.size() != int'(pkt_len)) begin
            errors++;
            $display("packet at %0t held %0d bytes but its length field said %0d",
                     $time, pkt_q.size(), pkt_len);
        end
        hdr = build_header(src, dst, int'(pkt_len));
        crc = 32'hffff_ffff;
        repeat (7) exp_q.push_back(8'h55);
        exp_q.push_back(8'hd5);
        for (int i = 0; i < 42; i++) begin
            b = hdr[335 - 8*i -: 8];
            exp_q.push_back(b);
            crc = crc_byte(crc, b);
        end
        foreach (pkt_q[i]) begin
            exp_q.push_back(pkt_q[i]);
            crc = crc_byte(crc, pkt_q[i]);
        end
        crc = ~crc;
        for (int i = 0; i < 4; i++) begin
            exp_q.push_back(crc[8*i +: 8]);
        end
        exp_len_q.push_back(pkt_q.size() + 54);
        pkt_q.delete();
    endtask

    always @(posedge clk_i) begin
        if (rst_i) begin
            first_byte = 1'b1;
            in_frame = 1'b0;
            hold_low = 1'b0;
            idle = GAP_CYCLES;
            cycle = 0;
            run = 0;
            errors = 0;
            frames = 0;
        end else begin
            cycle++;
            if (hold_low && s_ready_i) begin
                errors++;
                $display("s_ready_o went high at %0t before the frame gap ended", $time);
            end
            // intake side
            if (s_valid_i && s_ready_i) begin
                if (first_byte) begin
                    pkt_len = s_len_i;
                end
                pkt_q.push_back(s_data_i);
                first_byte = s_last_i;
                if (s_last_i) begin
                    queue_frame(local_i, remote_i);
                    accept_q.push_back(cycle);
                    hold_low = 1'b1;
                end
            end
            // gmii side
            if (tx_en_i) begin
                if (!in_frame) begin
                    in_frame = 1'b1;
                    run = 0;
                    if (idle < GAP_CYCLES) begin
                        errors++;
                        $display("[ERROR] %0t tx_en_o idle cycles expected >= %0d got %0d",
                                 $time, GAP_CYCLES, idle);
                    end
                    if (accept_q.size() == 0) begin
                        errors++;
                        $display("tx_en_o rose at %0t with no packet accepted", $time);
                    end else begin
                        start = cycle - accept_q.pop_front();
                        if (start != START_DELAY) begin
                            errors++;
                            $display("[ERROR] %0t tx_en_o start delay expected %0d got %0d",
                                     $time, START_DELAY, start);
                        end
                    end
                end
                if (exp_q.size() != 0) begin
                    exp_byte = exp_q.pop_front();
                    if (tx_d_i !== exp_byte) begin
                        errors++;
                        $display("[ERROR] %0t tx_d_o frame %0d byte %0d expected %02h got %02h",
                                 $time, frames, run, exp_byte, tx_d_i);
                    end
                end
                run++;
            end else if (in_frame) begin
                in_frame = 1'b0;
                idle = 1;
                exp_len = (exp_len_q.size() != 0) ? exp_len_q.pop_front() : 0;
                if (run != exp_len) begin
                    errors++;
                    $display("[ERROR] %0t tx_en_o high cycles expected %0d got %0d",
                             $time, exp_len, run);
                end
                // drop what a short frame left behind
                exp_q.delete();
                frames++;
            end else begin
                idle++;
            end
            if (!in_frame && idle == GAP_CYCLES) begin
                hold_low = 1'b0;
            end
        end
    end

    assign errors_o = errors;
    assign frames_o = frames;

endmodule

// ==== verification/udp_tx_tb.sv ====
module udp_tx_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import eth_frame_pkg::*;
    import udp_header_pkg::*;

    localparam int ROWS = 6;
    localparam int RESET_CYCLES = 16;
    localparam logic [31:0] LFSR_SEED = 32'hf29c_3845;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    typedef struct packed {
        logic [LEN_W-1:0] len;
        udp_endpoint_t    local_ep;
        udp_endpoint_t    remote_ep;
        logic             gaps;
    } test_row_t;

    logic          clk;
    logic          rst;
    udp_endpoint_t local_ep;
    udp_endpoint_t remote_ep;
    logic [7:0]    s_data;
    logic [LEN_W-1:0] s_len;
    logic          s_valid;
    logic          s_last;
    logic          s_ready;
    logic          tx_en;
    logic [7:0]    tx_d;
    logic [31:0]   lfsr_q;
    int            chk_errors;
    int            frames_seen;

    udp_tx_top dut0 (
        .clk_i    (clk),
        .rst_i    (rst),
        .local_i  (local_ep),
        .remote_i (remote_ep),
        .s_data_i (s_data),
        .s_len_i  (s_len),
        .s_valid_i(s_valid),
        .s_last_i (s_last),
        .s_ready_o(s_ready),
        .tx_en_o  (tx_en),
        .tx_d_o   (tx_d)
    );

    udp_tx_checker u_checker (
        .clk_i    (clk),
        .rst_i    (rst),
        .local_i  (local_ep),
        .remote_i (remote_ep),
        .s_data_i (s_data),
        .s_len_i  (s_len),
        .s_valid_i(s_valid),
        .s_last_i (s_last),
        .s_ready_i(s_ready),
        .tx_en_i  (tx_en),
        .tx_d_i   (tx_d),
        .errors_o (chk_errors),
        .frames_o (frames_seen)
    );

    // length, local mac/ip/port, remote mac/ip/port, valid gaps
    function automatic test_row_t table_row(input int idx);
        case (idx)
            0: return {11'd18, 48'h02_00_00_00_00_01, 32'hc0a8_0001, 16'h1388,
                       48'h02_00_00_00_00_02, 32'hc0a8_0002, 16'h1770, 1'b0};
            1: return {11'd19, 48'h00_1b_21_3a_4c_5d, 32'h0a00_0001, 16'h0400,
                       48'hff_ff_ff_ff_ff_ff, 32'h0a00_00ff, 16'h0035, 1'b1};
            // high addresses force carries out of the word sum
            2: return {11'd64, 48'h02_aa_bb_cc_dd_ee, 32'hffff_fffe, 16'hffff,
                       48'h02_11_22_33_44_55, 32'hffff_ff00, 16'h8000, 1'b0};
            3: return {11'd200, 48'h02_00_00_00_00_10, 32'hfffe_ffff, 16'h0001,
                       48'h02_00_00_00_00_20, 32'hffff_fffd, 16'hfffe, 1'b0};
            4: return {11'd1472, 48'h02_12_34_56_78_9a, 32'hc0a8_0a01, 16'h2710,
                       48'h02_9a_78_56_34_12, 32'hc0a8_0a02, 16'h2711, 1'b0};
            default: return {11'd37, 48'h02_fe_dc_ba_98_76, 32'hff00_ff00, 16'h7fff,
                             48'h02_01_02_03_04_05, 32'hffff_ffff, 16'h0007, 1'b1};
        endcase
    endfunction

    function automatic int timeout_limit();
        int        sum;
        test_row_t row;
        sum = RESET_CYCLES;
        for (int r = 0; r < ROWS; r++) begin
            row = table_row(r);
            sum += 2 * int'(row.len) + 80;
        end
        return sum;
    endfunction

    function automatic logic take_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ LFSR_TAPS;
        end
        return b;
    endfunction

    function automatic logic [7:0] take_byte();
        logic [7:0] v;
        v = '0;
        repeat (8) v = {v[6:0], take_bit()};
        return v;
    endfunction

    task automatic send_packet(input test_row_t row);
        int   sent;
        logic have_byte;
        logic gap;
        logic last_gap;
        sent = 0;
        have_byte = 1'b0;
        last_gap = 1'b0;
        while (sent < int'(row.len)) begin
            @(negedge clk);
            if (!have_byte) begin
                // never two idle cycles in a row
                gap = row.gaps ? (take_bit() && !last_gap) : 1'b0;
                last_gap = gap;
                if (!gap) begin
                    s_data = take_byte();
                    s_len = row.len;
                    s_last = (sent == int'(row.len) - 1);
                    have_byte = 1'b1;
                end
            end
            s_valid = have_byte;
            @(posedge clk);
            if (s_valid && s_ready) begin
                have_byte = 1'b0;
                sent++;
            end
        end
        @(negedge clk);
        s_valid = 1'b0;
        s_last = 1'b0;
    endtask

    task automatic end_run(input logic timed_out);
        int asrt_errors;
        asrt_errors = dut0.u_assertions.fail_count;
        $display("errors: checker %0d, assertions %0d; frames %0d of %0d",
                 chk_errors, asrt_errors, frames_seen, ROWS);
        if (!timed_out && chk_errors == 0 && asrt_errors == 0 && frames_seen == ROWS) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin : stimulus
        test_row_t row;
        lfsr_q = LFSR_SEED;
        rst = 1'b1;
        local_ep = '0;
        remote_ep = '0;
        s_data = '0;
        s_len = '0;
        s_valid = 1'b0;
        s_last = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        for (int r = 0; r < ROWS; r++) begin
            row = table_row(r);
            local_ep = row.local_ep;
            remote_ep = row.remote_ep;
            send_packet(row);
        end
        while (frames_seen < ROWS) @(negedge clk);
        while (!s_ready) @(negedge clk);
        end_run(1'b0);
    end

    initial begin : watchdog
        int limit;
        int cycles;
        limit = timeout_limit();
        cycles = 0;
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        end_run(1'b1);
    end

endmodule
